/* hw/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

// register index width
`define RV_REG_W 5

// one enable per byte lane of the bus
`define RV_BE_W 4

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* hw/rv_pkg.sv */
`include "rv_macros.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_W-1:0] reg_idx_t;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_IMM    = 7'b0010011,
        OPC_REG    = 7'b0110011,
        OPC_FENCE  = 7'b0001111
    } opcode_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SRL, SRA, XOR, OR, AND,
        LT, LTU, GE, GEU, EQ, NE
    } alu_op_t;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_t;

    typedef enum logic [2:0] {
        FETCH_SETUP, FETCH, EXECUTE, MEMORY, WRITEBACK, HALT
    } core_state_t;

    typedef enum logic [1:0] {LHS_REG, LHS_PC, LHS_ZERO} lhs_sel_t;
    typedef enum logic [1:0] {RHS_REG, RHS_IMM, RHS_SHAMT} rhs_sel_t;

    typedef struct packed {
        opcode_t opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        alu_op_t alu_op;
        lhs_sel_t lhs_sel;
        rhs_sel_t rhs_sel;
        word_t imm;
        word_t branch_offset;
        mem_size_t mem_size;
        logic mem_unsigned;
        logic is_load;
        logic is_store;
        logic is_branch;
        logic is_jal;
        logic is_jalr;
        logic writes_rd;
        logic illegal;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t write_data;
        logic [`RV_BE_W-1:0] byte_enable;
        logic write_req;
        logic read_req;
    } mem_req_t;

endpackage

/* hw/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu (
    input rv_pkg::alu_op_t op,
    input rv_pkg::word_t lhs,
    input rv_pkg::word_t rhs,
    output rv_pkg::word_t res
);

    logic [4:0] shamt;

    assign shamt = rhs[4:0];

    always_comb begin
        res = '0;
        case (op)
            rv_pkg::ADD: res = lhs + rhs;
            rv_pkg::SUB: res = lhs - rhs;
            rv_pkg::SLL: res = lhs << shamt;
            rv_pkg::SRL: res = lhs >> shamt;
            rv_pkg::SRA: res = $signed(lhs) >>> shamt;
            rv_pkg::XOR: res = lhs ^ rhs;
            rv_pkg::OR:  res = lhs | rhs;
            rv_pkg::AND: res = lhs & rhs;
            // compares only set bit 0
            rv_pkg::LT:  res[0] = $signed(lhs) < $signed(rhs);
            rv_pkg::LTU: res[0] = lhs < rhs;
            rv_pkg::GE:  res[0] = $signed(lhs) >= $signed(rhs);
            rv_pkg::GEU: res[0] = lhs >= rhs;
            rv_pkg::EQ:  res[0] = lhs == rhs;
            rv_pkg::NE:  res[0] = lhs != rhs;
            default:     res = '0;
        endcase
    end

endmodule

/* hw/rv_decoder.sv */
`timescale 1ns/100ps

module rv_decoder (
    input rv_pkg::word_t instruction,
    output rv_pkg::decoded_t decoded
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv_pkg::word_t i_imm;
    rv_pkg::word_t s_imm;
    rv_pkg::word_t b_imm;
    rv_pkg::word_t u_imm;
    rv_pkg::word_t j_imm;
    rv_pkg::alu_op_t arith_op;
    logic arith_ok;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    assign i_imm = {{20{instruction[31]}}, instruction[31:20]};
    assign s_imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign b_imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign u_imm = {instruction[31:12], 12'h000};
    assign j_imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    // opcode[5] marks the register form
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (funct7[5] && opcode[5]) ? rv_pkg::SUB : rv_pkg::ADD;
            3'b001:  arith_op = rv_pkg::SLL;
            3'b010:  arith_op = rv_pkg::LT;
            3'b011:  arith_op = rv_pkg::LTU;
            3'b100:  arith_op = rv_pkg::XOR;
            3'b101:  arith_op = funct7[5] ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  arith_op = rv_pkg::OR;
            default: arith_op = rv_pkg::AND;
        endcase

        // immediate non-shifts ignore funct7
        if (!opcode[5] && funct3[1:0] != 2'b01) begin
            arith_ok = 1'b1;
        end else if (funct7 == 7'b0000000) begin
            arith_ok = 1'b1;
        end else begin
            arith_ok = funct7 == 7'b0100000 &&
                       (funct3 == 3'b101 || (funct3 == 3'b000 && opcode[5]));
        end
    end

    always_comb begin
        decoded = '0;
        decoded.opcode = rv_pkg::opcode_t'(opcode);
        decoded.rd = instruction[11:7];
        decoded.rs1 = instruction[19:15];
        decoded.rs2 = instruction[24:20];
        decoded.branch_offset = b_imm;
        // whole words pass the LSU unless a load or store narrows them
        decoded.mem_size = rv_pkg::WORD;
        decoded.mem_unsigned = funct3[2];

        case (decoded.opcode)
            rv_pkg::OPC_LUI: begin
                decoded.lhs_sel = rv_pkg::LHS_ZERO;
                decoded.rhs_sel = rv_pkg::RHS_IMM;
                decoded.imm = u_imm;
                decoded.writes_rd = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                decoded.lhs_sel = rv_pkg::LHS_PC;
                decoded.rhs_sel = rv_pkg::RHS_IMM;
                decoded.imm = u_imm;
                decoded.writes_rd = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                decoded.lhs_sel = rv_pkg::LHS_PC;
                decoded.rhs_sel = rv_pkg::RHS_IMM;
                decoded.imm = j_imm;
                decoded.is_jal = 1'b1;
                decoded.writes_rd = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                decoded.rhs_sel = rv_pkg::RHS_IMM;
                decoded.imm = i_imm;
                decoded.is_jalr = 1'b1;
                decoded.writes_rd = 1'b1;
                decoded.illegal = funct3 != 3'b000;
            end
            rv_pkg::OPC_BRANCH: begin
                decoded.is_branch = 1'b1;
                case (funct3)
                    3'b000:  decoded.alu_op = rv_pkg::EQ;
                    3'b001:  decoded.alu_op = rv_pkg::NE;
                    3'b100:  decoded.alu_op = rv_pkg::LT;
                    3'b101:  decoded.alu_op = rv_pkg::GE;
                    3'b110:  decoded.alu_op = rv_pkg::LTU;
                    3'b111:  decoded.alu_op = rv_pkg::GEU;
                    default: decoded.illegal = 1'b1;
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                decoded.rhs_sel = rv_pkg::RHS_IMM;
                decoded.imm = i_imm;
                decoded.mem_size = rv_pkg::mem_size_t'(funct3[1:0]);
                decoded.is_load = 1'b1;
                decoded.writes_rd = 1'b1;
                decoded.illegal = funct3 == 3'b011 || funct3[2:1] == 2'b11;
            end
            rv_pkg::OPC_STORE: begin
                decoded.rhs_sel = rv_pkg::RHS_IMM;
                decoded.imm = s_imm;
                decoded.mem_size = rv_pkg::mem_size_t'(funct3[1:0]);
                decoded.is_store = 1'b1;
                decoded.illegal = funct3[2] || funct3[1:0] == 2'b11;
            end
            rv_pkg::OPC_IMM: begin
                decoded.alu_op = arith_op;
                decoded.rhs_sel = (funct3[1:0] == 2'b01) ? rv_pkg::RHS_SHAMT : rv_pkg::RHS_IMM;
                decoded.imm = i_imm;
                decoded.writes_rd = 1'b1;
                decoded.illegal = !arith_ok;
            end
            rv_pkg::OPC_REG: begin
                decoded.alu_op = arith_op;
                decoded.writes_rd = 1'b1;
                decoded.illegal = !arith_ok;
            end
            // fence retires with no effect
            rv_pkg::OPC_FENCE: decoded.writes_rd = 1'b0;
            default: decoded.illegal = 1'b1;
        endcase
    end

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_regfile (
    input logic clk,
    input logic reset_n,
    input rv_pkg::reg_idx_t rs1,
    input rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t rs1_value,
    output rv_pkg::word_t rs2_value,
    input logic write_enable,
    input rv_pkg::reg_idx_t rd,
    input rv_pkg::word_t write_value
);

    rv_pkg::word_t regs [0:`RV_NREGS-1];

    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd != '0) begin
            regs[rd] <= write_value;
        end
    end

endmodule

/* hw/rv_lsu.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_lsu (
    input rv_pkg::mem_size_t size,
    input logic is_unsigned,
    input logic [1:0] addr_low,
    input rv_pkg::word_t store_value,
    output rv_pkg::word_t store_data,
    output logic [`RV_BE_W-1:0] store_be,
    input rv_pkg::word_t read_data,
    output rv_pkg::word_t load_value
);

    logic [4:0] lane_shift;
    rv_pkg::word_t lanes;

    assign lane_shift = {addr_low, 3'b000};

    // aligned only, so the value never spills past the top lane
    assign store_data = store_value << lane_shift;

    // selected lanes moved down to bit 0
    assign lanes = read_data >> lane_shift;

    always_comb begin
        case (size)
            rv_pkg::BYTE: begin
                store_be = 4'b0001 << addr_low;
                if (is_unsigned) begin
                    load_value = {24'h000000, lanes[7:0]};
                end else begin
                    load_value = {{24{lanes[7]}}, lanes[7:0]};
                end
            end
            rv_pkg::HALF: begin
                store_be = 4'b0011 << addr_low;
                if (is_unsigned) begin
                    load_value = {16'h0000, lanes[15:0]};
                end else begin
                    load_value = {{16{lanes[15]}}, lanes[15:0]};
                end
            end
            default: begin
                store_be = 4'b1111;
                load_value = read_data;
            end
        endcase
    end

endmodule

/* hw/rv_control.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_control (
    input logic clk,
    input logic reset_n,
    input logic ready,
    input logic read_data_valid,
    input rv_pkg::decoded_t decoded,
    input rv_pkg::word_t rs1_value,
    input rv_pkg::word_t rs2_value,
    input rv_pkg::word_t alu_res,
    input rv_pkg::word_t load_value,
    input rv_pkg::word_t store_data,
    input logic [`RV_BE_W-1:0] store_be,
    output rv_pkg::word_t instruction,
    output rv_pkg::alu_op_t alu_op,
    output rv_pkg::word_t alu_lhs,
    output rv_pkg::word_t alu_rhs,
    output logic rd_write_enable,
    output rv_pkg::reg_idx_t rd,
    output rv_pkg::word_t rd_write_value,
    output logic [1:0] mem_addr_low,
    output rv_pkg::mem_req_t mem_req,
    output logic halted
);

    rv_pkg::core_state_t state;
    rv_pkg::word_t pc;
    rv_pkg::word_t pc_next;
    rv_pkg::word_t link;
    logic mem_done;
    logic addr_misaligned;

    assign rd = decoded.rd;
    assign mem_addr_low = alu_res[1:0];
    assign halted = state == rv_pkg::HALT;

    always_comb begin
        link = pc + 32'd4;

        pc_next = link;
        if (decoded.is_jal) begin
            pc_next = alu_res;
        end else if (decoded.is_jalr) begin
            pc_next = {alu_res[31:1], 1'b0};
        end else if (decoded.is_branch && alu_res[0]) begin
            pc_next = pc + decoded.branch_offset;
        end

        case (decoded.mem_size)
            rv_pkg::BYTE: addr_misaligned = 1'b0;
            rv_pkg::HALF: addr_misaligned = alu_res[0];
            default:      addr_misaligned = alu_res[1:0] != 2'b00;
        endcase

        // load data may trail ready once read_req is low
        if (decoded.is_load) begin
            mem_done = read_data_valid && (ready || !mem_req.read_req);
        end else if (decoded.is_store) begin
            mem_done = ready;
        end else begin
            mem_done = 1'b1;
        end

        rd_write_enable = state == rv_pkg::WRITEBACK && mem_done && decoded.writes_rd &&
                          pc_next[1:0] == 2'b00;
        if (decoded.is_load) begin
            rd_write_value = load_value;
        end else if (decoded.is_jal || decoded.is_jalr) begin
            rd_write_value = link;
        end else begin
            rd_write_value = alu_res;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= rv_pkg::FETCH_SETUP;
            pc <= `RV_RESET_PC;
            instruction <= '0;
            alu_op <= rv_pkg::ADD;
            alu_lhs <= '0;
            alu_rhs <= '0;
            mem_req <= '0;
        end else begin
            case (state)
                rv_pkg::FETCH_SETUP: begin
                    mem_req.addr <= pc;
                    mem_req.byte_enable <= '1;
                    mem_req.read_req <= 1'b1;
                    state <= rv_pkg::FETCH;
                end
                rv_pkg::FETCH: begin
                    if (ready) begin
                        mem_req.read_req <= 1'b0;
                    end
                    if (read_data_valid && (ready || !mem_req.read_req)) begin
                        instruction <= load_value;
                        state <= rv_pkg::EXECUTE;
                    end
                end
                rv_pkg::EXECUTE: begin
                    alu_op <= decoded.alu_op;
                    case (decoded.lhs_sel)
                        rv_pkg::LHS_REG: alu_lhs <= rs1_value;
                        rv_pkg::LHS_PC:  alu_lhs <= pc;
                        default:         alu_lhs <= '0;
                    endcase
                    case (decoded.rhs_sel)
                        rv_pkg::RHS_REG: alu_rhs <= rs2_value;
                        rv_pkg::RHS_IMM: alu_rhs <= decoded.imm;
                        default:         alu_rhs <= rv_pkg::word_t'(decoded.rs2);
                    endcase
                    if (decoded.illegal) begin
                        state <= rv_pkg::HALT;
                    end else if (decoded.is_load || decoded.is_store) begin
                        state <= rv_pkg::MEMORY;
                    end else begin
                        state <= rv_pkg::WRITEBACK;
                    end
                end
                rv_pkg::MEMORY: begin
                    // alu_res holds the effective address here
                    if (addr_misaligned) begin
                        state <= rv_pkg::HALT;
                    end else begin
                        mem_req.addr <= {alu_res[31:2], 2'b00};
                        mem_req.write_data <= store_data;
                        mem_req.byte_enable <= store_be;
                        mem_req.read_req <= decoded.is_load;
                        mem_req.write_req <= decoded.is_store;
                        state <= rv_pkg::WRITEBACK;
                    end
                end
                rv_pkg::WRITEBACK: begin
                    if (ready) begin
                        mem_req.read_req <= 1'b0;
                        mem_req.write_req <= 1'b0;
                    end
                    if (mem_done) begin
                        if (pc_next[1:0] != 2'b00) begin
                            state <= rv_pkg::HALT;
                        end else begin
                            pc <= pc_next;
                            // no access size, so the fetched word passes the LSU whole
                            instruction <= '0;
                            mem_req.addr <= pc_next;
                            mem_req.byte_enable <= '1;
                            mem_req.read_req <= 1'b1;
                            state <= rv_pkg::FETCH;
                        end
                    end
                end
                // stays here until reset
                default: state <= rv_pkg::HALT;
            endcase
        end
    end

endmodule

/* hw/rv_cpu.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module rv_cpu (
    input logic clk,
    input logic reset_n,
    output rv_pkg::mem_req_t mem_req,
    input logic ready,
    input rv_pkg::word_t read_data,
    input logic read_data_valid,
    output logic halted
);

    rv_pkg::decoded_t decoded;
    rv_pkg::word_t instruction;
    rv_pkg::word_t rs1_value;
    rv_pkg::word_t rs2_value;
    rv_pkg::alu_op_t alu_op;
    rv_pkg::word_t alu_lhs;
    rv_pkg::word_t alu_rhs;
    rv_pkg::word_t alu_res;
    logic rd_write_enable;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t rd_write_value;
    rv_pkg::word_t load_value;
    rv_pkg::word_t store_data;
    logic [`RV_BE_W-1:0] store_be;
    logic [1:0] mem_addr_low;

    rv_control control (
        .clk(clk),
        .reset_n(reset_n),
        .ready(ready),
        .read_data_valid(read_data_valid),
        .decoded(decoded),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .alu_res(alu_res),
        .load_value(load_value),
        .store_data(store_data),
        .store_be(store_be),
        .instruction(instruction),
        .alu_op(alu_op),
        .alu_lhs(alu_lhs),
        .alu_rhs(alu_rhs),
        .rd_write_enable(rd_write_enable),
        .rd(rd),
        .rd_write_value(rd_write_value),
        .mem_addr_low(mem_addr_low),
        .mem_req(mem_req),
        .halted(halted)
    );

    rv_decoder decoder (
        .instruction(instruction),
        .decoded(decoded)
    );

    rv_regfile regfile (
        .clk(clk),
        .reset_n(reset_n),
        .rs1(decoded.rs1),
        .rs2(decoded.rs2),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .write_enable(rd_write_enable),
        .rd(rd),
        .write_value(rd_write_value)
    );

    rv_alu alu (
        .op(alu_op),
        .lhs(alu_lhs),
        .rhs(alu_rhs),
        .res(alu_res)
    );

    rv_lsu lsu (
        .size(decoded.mem_size),
        .is_unsigned(decoded.mem_unsigned),
        .addr_low(mem_addr_low),
        .store_value(rs2_value),
        .store_data(store_data),
        .store_be(store_be),
        .read_data(read_data),
        .load_value(load_value)
    );

endmodule

/* tests/tb_rv_cpu.sv */
`timescale 1ns/100ps
`include "rv_macros.svh"

module tb_rv_cpu;

    localparam int MEM_WORDS = 1024;
    localparam int TABLE_BASE = 'h100;
    localparam int NUM_INSTR = 42;
    localparam int RUN_CYCLES = NUM_INSTR * 8 * 4;
    localparam int SETTLE_CYCLES = 10;

    logic clk;
    logic reset_n;
    rv_pkg::mem_req_t mem_req;
    logic ready;
    rv_pkg::word_t read_data;
    logic read_data_valid;
    logic halted;

    rv_pkg::word_t mem [0:MEM_WORDS-1];
    integer seed;
    int value_errors;
    int protocol_errors;
    int stores_checked;
    int rec_idx;

    rv_cpu dut (
        .clk(clk),
        .reset_n(reset_n),
        .mem_req(mem_req),
        .ready(ready),
        .read_data(read_data),
        .read_data_valid(read_data_valid),
        .halted(halted)
    );

    always #5 clk = ~clk;

    // two runs with reset and settle time on top
    initial begin
        #(2 * (RUN_CYCLES + SETTLE_CYCLES + 10) * 10);
        $display("watchdog expired, the core did not reach halt in time");
        $display("Test failed");
        $finish;
    end

    task automatic check_req(input rv_pkg::mem_req_t actual, input rv_pkg::mem_req_t expected,
                             input string what);
        rv_pkg::word_t mask;
        mask = '0;
        // only enabled lanes of write data matter
        for (int i = 0; i < `RV_BE_W; i++) begin
            if (expected.write_req && expected.byte_enable[i]) begin
                mask[8*i +: 8] = 8'hff;
            end
        end
        if (actual.addr !== expected.addr || actual.byte_enable !== expected.byte_enable ||
            actual.write_req !== expected.write_req || actual.read_req !== expected.read_req ||
            ((actual.write_data ^ expected.write_data) & mask) !== '0) begin
            value_errors++;
            $display("FAILED at %0t: %s got addr %h data %h be %b w %b r %b", $time, what,
                     actual.addr, actual.write_data, actual.byte_enable,
                     actual.write_req, actual.read_req);
            $display("FAILED at %0t: %s expected addr %h data %h be %b w %b r %b", $time, what,
                     expected.addr, expected.write_data, expected.byte_enable,
                     expected.write_req, expected.read_req);
        end
    endtask

    task automatic check_halt(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED at %0t: %s, halted is %b, expected %b", $time, what,
                     actual, expected);
        end
    endtask

    task automatic load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hbad0_0000 | i;
        end
        $readmemh("tests/rv_patterns.hex", mem);
    endtask

    function automatic rv_pkg::mem_req_t expected_store(input int idx);
        rv_pkg::mem_req_t r;
        r = '0;
        r.addr = mem[TABLE_BASE + idx*4];
        r.write_data = mem[TABLE_BASE + idx*4 + 1];
        r.byte_enable = mem[TABLE_BASE + idx*4 + 2][`RV_BE_W-1:0];
        r.write_req = 1'b1;
        return r;
    endfunction

    task automatic handle_store(input rv_pkg::mem_req_t req);
        if (mem[TABLE_BASE + rec_idx*4 + 3][0]) begin
            protocol_errors++;
            $display("a store to %h was issued after the last expected store", req.addr);
        end else begin
            check_req(req, expected_store(rec_idx), "store");
            for (int i = 0; i < `RV_BE_W; i++) begin
                if (req.byte_enable[i]) begin
                    mem[req.addr[11:2]][8*i +: 8] = req.write_data[8*i +: 8];
                end
            end
            stores_checked++;
            rec_idx++;
        end
    endtask

    task automatic run_program(input bit stall);
        rv_pkg::mem_req_t prev_req;
        rv_pkg::mem_req_t first_fetch;
        rv_pkg::mem_req_t last_read;
        rv_pkg::mem_req_t last_fetch;
        logic pending;
        load_memory();
        rec_idx = 0;
        pending = 1'b0;
        prev_req = '0;
        last_read = '0;
        reset_n = 1'b0;
        ready = 1'b0;
        read_data_valid = 1'b0;
        read_data = '0;
        repeat (5) begin
            @(negedge clk);
            if (mem_req.read_req || mem_req.write_req) begin
                protocol_errors++;
                $display("a request was issued during reset");
            end
        end
        reset_n = 1'b1;
        check_halt(halted, 1'b0, "after reset");
        if (mem_req.read_req || mem_req.write_req) begin
            protocol_errors++;
            $display("a request was issued in the first cycle after reset");
        end
        @(negedge clk);
        first_fetch = '0;
        first_fetch.addr = `RV_RESET_PC;
        first_fetch.byte_enable = '1;
        first_fetch.read_req = 1'b1;
        check_req(mem_req, first_fetch, "first fetch");

        while (!halted) begin
            if (mem_req.read_req && mem_req.write_req) begin
                protocol_errors++;
                $display("read and write requested together at %h", mem_req.addr);
            end
            if (pending && mem_req !== prev_req) begin
                protocol_errors++;
                $display("request fields changed while waiting for ready");
            end
            ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
            read_data_valid = ready && mem_req.read_req;
            read_data = mem[mem_req.addr[11:2]];
            if (ready && mem_req.read_req) begin
                last_read = mem_req;
            end
            if (ready && mem_req.write_req) begin
                handle_store(mem_req);
            end
            prev_req = mem_req;
            pending = (mem_req.read_req || mem_req.write_req) && !ready;
            @(negedge clk);
        end

        // halting here is right only when the table says so
        check_halt(halted, mem[TABLE_BASE + rec_idx*4 + 3][0], "end of program");
        // the misaligned sw is the last word of the program
        last_fetch = '0;
        last_fetch.addr = (NUM_INSTR - 1) * 4;
        last_fetch.byte_enable = '1;
        last_fetch.read_req = 1'b1;
        check_req(last_read, last_fetch, "last fetch");
        ready = 1'b1;
        read_data_valid = 1'b0;
        repeat (SETTLE_CYCLES) begin
            if (mem_req.read_req || mem_req.write_req) begin
                protocol_errors++;
                $display("a request was issued after the core halted");
            end
            @(negedge clk);
        end
        check_halt(halted, 1'b1, "after settle");
    endtask

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        ready = 1'b0;
        read_data = '0;
        read_data_valid = 1'b0;
        seed = 32'ha733dfaa;
        value_errors = 0;
        protocol_errors = 0;
        stores_checked = 0;
        @(negedge clk);
        // ready held high first and random stalls after
        run_program(1'b0);
        run_program(1'b1);
        $display("value errors %0d, protocol errors %0d, stores checked %0d",
                 value_errors, protocol_errors, stores_checked);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/rv_pkg.sv
hw/rv_alu.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_lsu.sv
hw/rv_control.sv
hw/rv_cpu.sv
tests/tb_rv_cpu.sv

/* Makefile */
# Verilator build and run of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_cpu
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/rv_patterns.hex */
// words from address 0: program image, four instructions per line
// words from @100: expected stores, each record is addr, data, byte enables, halt marker
@000
20000093 FFB00113 00700193 00310233
0040A023 402182B3 0050A223 00312333
003133B3 0060A423 0070A623 0F014413
40445493 0090A823 12345537 00A0AA23
00001597 00B0AC23 00310463 0030AE23
00314463 0220A023 0080066F 0220A023
02C0A223 07400693 00068767 0220A023
0220A023 02E0A423 028086A3 02909723
02E09783 02E0D803 02F08883 02D0C903
02F0A823 0300AA23 0310AC23 0320AE23
0000000F 0030A123
@100
00000200 00000002 0000000F 00000000
00000204 0000000C 0000000F 00000000
00000208 00000001 0000000F 00000000
0000020C 00000000 0000000F 00000000
00000210 FFFFFFF0 0000000F 00000000
00000214 12345000 0000000F 00000000
00000218 00001040 0000000F 00000000
0000021C 00000007 0000000F 00000000
00000224 0000005C 0000000F 00000000
00000228 0000006C 0000000F 00000000
0000022C 00000B00 00000002 00000000
0000022C FFF00000 0000000C 00000000
00000230 FFFFFFF0 0000000F 00000000
00000234 0000FFF0 0000000F 00000000
00000238 FFFFFFFF 0000000F 00000000
0000023C 0000000B 0000000F 00000000
00000000 00000000 00000000 00000001
